//--- design/mem_pkg.sv
`default_nettype none

// memory side constants shared by cache, memory and bench
package mem_pkg;

	localparam int ADDR_W = 16;        // byte address width
	localparam int DATA_W = 16;        // one memory word

	localparam int MEM_WORDS = 32768;  // word addressed by addr[15:1]

	localparam int MEM_LATENCY = 4;    // read request to data_valid

	// initial word at word address a is a ^ MEM_INIT_KEY
	localparam logic [DATA_W-1:0] MEM_INIT_KEY = 16'hA5C3;

endpackage

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

// cache geometry and the address view used for set lookup
package cache_pkg;

	localparam int TAG_W = 5;          // addr[15:11]
	localparam int INDEX_W = 7;        // addr[10:4]
	localparam int OFFSET_W = 4;       // addr[3:0], bit 0 unused

	localparam int SETS = 128;         // one block per set
	localparam int WORDS_PER_BLOCK = 8;

	// stall length of one fill: eight issues plus the memory latency
	localparam int FILL_CYCLES = WORDS_PER_BLOCK + mem_pkg::MEM_LATENCY;

	// one address word seen either raw or split into fields
	typedef union packed {
		logic [mem_pkg::ADDR_W-1:0] raw;   // plain byte address
		struct packed {
			logic [TAG_W-1:0]    tag;     // compared against tag array
			logic [INDEX_W-1:0]  index;   // selects the set
			logic [OFFSET_W-1:0] offset;  // word in block is offset[3:1]
		} f;
	} cache_addr_u;

endpackage

`default_nettype wire

//--- design/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// bus between the cache and main memory, plain levels and a strobe
interface mem_bus_if;

	logic                         mem_read;    // one read request per high cycle
	logic                         mem_write;   // write at this edge
	logic [mem_pkg::ADDR_W-1:0]   addr;        // byte address
	logic [mem_pkg::DATA_W-1:0]   wdata;       // write data
	logic [mem_pkg::DATA_W-1:0]   rdata;       // returned word
	logic                         data_valid;  // marks rdata for one cycle

	modport cache_side (
		output mem_read,
		output mem_write,
		output addr,
		output wdata,
		input  rdata,
		input  data_valid
	);

	modport mem_side (
		input  mem_read,
		input  mem_write,
		input  addr,
		input  wdata,
		output rdata,
		output data_valid
	);

endinterface

`default_nettype wire

//--- design/tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module tag_array (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        write,    // load tag and set valid
	input  logic [cache_pkg::INDEX_W-1:0] index,  // set select
	input  logic [cache_pkg::TAG_W-1:0]   tag_in,
	output logic                        valid,    // entry at index holds a block
	output logic [cache_pkg::TAG_W-1:0]   tag_out
);

	logic [cache_pkg::SETS-1:0]  set_sel;                    // one-hot set decode
	logic [cache_pkg::SETS-1:0]  valid_bits;                 // one per set
	logic [cache_pkg::TAG_W-1:0] tags [cache_pkg::SETS];     // tag store

	assign set_sel = {{(cache_pkg::SETS-1){1'b0}}, 1'b1} << index;

	// valid bits only ever get set, reset wipes the whole cache
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
		end else if (write) begin
			valid_bits <= valid_bits | set_sel;  // mark the decoded set
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < cache_pkg::SETS; s++) begin
			if (write && set_sel[s]) begin
				tags[s] <= tag_in;           // only the selected entry
			end
		end
	end

	assign valid   = valid_bits[index];        // combinational lookup
	assign tag_out = tags[index];

endmodule

`default_nettype wire

//--- design/data_array.sv
`timescale 1ns/1ps
`default_nettype none

module data_array (
	input  logic                            clk,
	input  logic                            write,     // store data_in at set/word
	input  logic [cache_pkg::INDEX_W-1:0]   index,     // set select
	input  logic [cache_pkg::OFFSET_W-2:0]  word,      // word within block
	input  logic [mem_pkg::DATA_W-1:0]      data_in,
	output logic [mem_pkg::DATA_W-1:0]      data_out   // async read
);

	logic [cache_pkg::SETS-1:0]            set_sel;    // one-hot block select
	logic [cache_pkg::WORDS_PER_BLOCK-1:0] word_sel;   // one-hot word select

	// block storage, contents only meaningful behind a valid tag
	logic [mem_pkg::DATA_W-1:0] blocks [cache_pkg::SETS][cache_pkg::WORDS_PER_BLOCK];

	assign set_sel  = {{(cache_pkg::SETS-1){1'b0}}, 1'b1} << index;
	assign word_sel = {{(cache_pkg::WORDS_PER_BLOCK-1){1'b0}}, 1'b1} << word;

	// a write lands where both decodes agree
	always_ff @(posedge clk) begin
		for (int s = 0; s < cache_pkg::SETS; s++) begin
			for (int w = 0; w < cache_pkg::WORDS_PER_BLOCK; w++) begin
				if (write && set_sel[s] && word_sel[w]) begin
					blocks[s][w] <= data_in;
				end
			end
		end
	end

	assign data_out = blocks[index][word];  // read sees the pre-edge value

endmodule

`default_nettype wire

//--- design/cache_fill_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cache_fill_fsm (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            miss,        // request missed while idle
	input  cache_pkg::cache_addr_u          miss_addr,   // address that missed
	input  logic                            data_valid,  // memory word returning
	output logic                            busy,        // fill in progress, drives stall
	output logic                            mem_read,    // block read request
	output logic [mem_pkg::ADDR_W-1:0]      mem_addr,    // block aligned read address
	output logic [cache_pkg::OFFSET_W-2:0]  fill_word,   // word slot for the returning data
	output logic                            write_data,  // write data array this cycle
	output logic                            write_tag    // last word, load tag too
);

	logic                           filling;     // state, 0 idle 1 filling
	logic                           issuing;     // read requests still going out
	logic [cache_pkg::OFFSET_W-2:0] issue_cnt;   // next word to request
	logic [cache_pkg::OFFSET_W-2:0] rcv_cnt;     // next word to arrive
	cache_pkg::cache_addr_u         base_q;      // latched miss address
	cache_pkg::cache_addr_u         block_addr;  // request address being built

	// the miss address is held here so the bus address
	// does not depend on the requester
	always_ff @(posedge clk) begin
		if (miss && !filling) begin
			base_q <= miss_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			filling   <= 1'b0;
			issuing   <= 1'b0;
			issue_cnt <= '0;
			rcv_cnt   <= '0;
		end else if (!filling) begin
			if (miss) begin
				filling   <= 1'b1;           // busy from the next cycle
				issuing   <= 1'b1;
				issue_cnt <= '0;
				rcv_cnt   <= '0;
			end
		end else begin
			if (issuing) begin
				issue_cnt <= issue_cnt + 1'b1;
				if (&issue_cnt) begin
					issuing <= 1'b0;          // eighth request sent
				end
			end
			if (data_valid) begin
				rcv_cnt <= rcv_cnt + 1'b1;
				if (&rcv_cnt) begin
					filling <= 1'b0;          // idle once the last word is in
				end
			end
		end
	end

	// same tag and set as the miss, offset walks the block
	always_comb begin
		block_addr.f.tag    = base_q.f.tag;
		block_addr.f.index  = base_q.f.index;
		block_addr.f.offset = {issue_cnt, 1'b0};  // word aligned
	end

	assign mem_addr   = block_addr.raw;
	assign mem_read   = issuing;
	assign busy       = filling;
	assign fill_word  = rcv_cnt;
	assign write_data = filling & data_valid;       // one array write per word
	assign write_tag  = write_data & (&rcv_cnt);    // tag goes in with word 7

endmodule

`default_nettype wire

//--- design/cache.sv
`timescale 1ns/1ps
`default_nettype none

module cache (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       pipe_read,    // read request level
	input  logic                       pipe_write,   // write request level
	input  logic [mem_pkg::ADDR_W-1:0] read_addr,
	input  logic [mem_pkg::ADDR_W-1:0] write_addr,
	input  logic [mem_pkg::DATA_W-1:0] write_data,
	output logic [mem_pkg::DATA_W-1:0] data_out,     // valid in the hit cycle
	output logic                       stall,        // hold the request during a fill
	output logic                       cachehit,
	mem_bus_if.cache_side              bus
);

	cache_pkg::cache_addr_u          req_addr;       // selected request address
	logic                            tag_valid;
	logic [cache_pkg::TAG_W-1:0]     tag_out;
	logic                            hit;
	logic                            miss;
	logic                            write_hit;      // write completes this cycle

	logic                            busy;           // fill controller active
	logic                            fill_read;
	logic [mem_pkg::ADDR_W-1:0]      fill_addr;
	logic [cache_pkg::OFFSET_W-2:0]  fill_word;
	logic                            fill_write;     // memory word into data array
	logic                            fill_tag;       // last word, tag update

	logic [cache_pkg::OFFSET_W-2:0]  array_word;
	logic [mem_pkg::DATA_W-1:0]      array_data_in;
	logic                            array_write;

	assign req_addr.raw = pipe_write ? write_addr : read_addr;  // write wins

	assign hit       = tag_valid & (tag_out == req_addr.f.tag);
	assign miss      = (pipe_read | pipe_write) & ~hit & ~busy;  // only start from idle
	assign write_hit = pipe_write & hit & ~busy;

	tag_array i_tags (
		.clk     (clk),
		.rst     (rst),
		.write   (fill_tag),
		.index   (req_addr.f.index),   // request is held through the fill
		.tag_in  (req_addr.f.tag),
		.valid   (tag_valid),
		.tag_out (tag_out)
	);

	// during a fill the array follows the controller, else the pipeline
	assign array_word    = busy ? fill_word : req_addr.f.offset[cache_pkg::OFFSET_W-1:1];
	assign array_data_in = busy ? bus.rdata : write_data;
	assign array_write   = fill_write | write_hit;

	data_array i_data (
		.clk      (clk),
		.write    (array_write),
		.index    (req_addr.f.index),
		.word     (array_word),
		.data_in  (array_data_in),
		.data_out (data_out)
	);

	cache_fill_fsm i_fill (
		.clk        (clk),
		.rst        (rst),
		.miss       (miss),
		.miss_addr  (req_addr),
		.data_valid (bus.data_valid),
		.busy       (busy),
		.mem_read   (fill_read),
		.mem_addr   (fill_addr),
		.fill_word  (fill_word),
		.write_data (fill_write),
		.write_tag  (fill_tag)
	);

	// write-through, memory sees every write hit in the same cycle
	assign bus.mem_read  = fill_read;
	assign bus.mem_write = write_hit;                          // blocked while busy
	assign bus.addr      = busy ? fill_addr : req_addr.raw;    // fill or write path
	assign bus.wdata     = write_data;

	assign stall    = busy;
	assign cachehit = hit;

endmodule

`default_nettype wire

//--- design/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory (
	input  logic         clk,
	input  logic         rst,
	mem_bus_if.mem_side  bus
);

	logic [mem_pkg::ADDR_W-2:0]      word_addr;                   // addr[15:1]
	logic [mem_pkg::DATA_W-1:0]      mem [mem_pkg::MEM_WORDS];    // word storage

	logic [mem_pkg::MEM_LATENCY-1:0] rd_valid;                    // one bit per stage
	logic [mem_pkg::DATA_W-1:0]      rd_word [mem_pkg::MEM_LATENCY];

	assign word_addr = bus.addr[mem_pkg::ADDR_W-1:1];  // byte to word

	// contents follow the address rule so any word is predictable
	initial begin
		for (int a = 0; a < mem_pkg::MEM_WORDS; a++) begin
			mem[a] = a[mem_pkg::DATA_W-1:0] ^ mem_pkg::MEM_INIT_KEY;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.mem_write) begin
			mem[word_addr] <= bus.wdata;   // single cycle write
		end
	end

	// valid bits shift with the request, reset drops anything in flight
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid <= '0;
		end else begin
			rd_valid <= {rd_valid[mem_pkg::MEM_LATENCY-2:0], bus.mem_read};
		end
	end

	// word sampled at request time then carried down the pipe
	always_ff @(posedge clk) begin
		rd_word[0] <= mem[word_addr];
		for (int i = 1; i < mem_pkg::MEM_LATENCY; i++) begin
			rd_word[i] <= rd_word[i-1];
		end
	end

	assign bus.rdata      = rd_word[mem_pkg::MEM_LATENCY-1];
	assign bus.data_valid = rd_valid[mem_pkg::MEM_LATENCY-1];  // MEM_LATENCY after request

endmodule

`default_nettype wire

//--- design/mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       pipe_read,    // read request level
	input  logic                       pipe_write,   // write request level
	input  logic [mem_pkg::ADDR_W-1:0] read_addr,
	input  logic [mem_pkg::ADDR_W-1:0] write_addr,
	input  logic [mem_pkg::DATA_W-1:0] write_data,
	output logic [mem_pkg::DATA_W-1:0] data_out,
	output logic                       stall,        // request must be held
	output logic                       cachehit
);

	mem_bus_if bus ();   // cache to memory

	cache i_cache (
		.clk        (clk),
		.rst        (rst),
		.pipe_read  (pipe_read),
		.pipe_write (pipe_write),
		.read_addr  (read_addr),
		.write_addr (write_addr),
		.write_data (write_data),
		.data_out   (data_out),
		.stall      (stall),
		.cachehit   (cachehit),
		.bus        (bus.cache_side)
	);

	main_memory i_mem (
		.clk (clk),
		.rst (rst),
		.bus (bus.mem_side)
	);

endmodule

`default_nettype wire

//--- bench/mem_system_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system_checker (
	input  logic clk,
	input  logic rst,
	input  logic stall,      // top level stall
	input  logic mem_write   // cache to memory write level
);

	localparam logic [7:0] MAX_STALL = 8'(cache_pkg::FILL_CYCLES);

	logic [7:0] stall_run;   // consecutive stall cycles so far

	always_ff @(posedge clk) begin
		if (rst) begin
			stall_run <= '0;
		end else if (!stall) begin
			stall_run <= '0;
		end else if (stall_run != 8'hFF) begin
			stall_run <= stall_run + 8'd1;  // saturates on a stuck stall
		end
	end

	stall_after_reset: assert property (@(posedge clk) rst |=> !stall)
		else $error("stall high in the cycle after reset");

	// writes are blocked while a fill owns the bus
	no_write_in_fill: assert property (@(posedge clk) disable iff (rst) stall |-> !mem_write)
		else $error("memory write during a fill");

	stall_bounded: assert property (@(posedge clk) disable iff (rst) stall_run <= MAX_STALL)
		else $error("stall longer than one fill");

endmodule

bind mem_system mem_system_checker i_checker (
	.clk       (clk),
	.rst       (rst),
	.stall     (stall),
	.mem_write (bus.mem_write)
);

`default_nettype wire

//--- bench/tb_mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;

	localparam int PERIOD       = 40;
	localparam int SAMPLE_DELAY = PERIOD / 4;     // outputs settled, well ahead of the rising edge
	localparam int NUM_RANDOM   = 400;
	localparam int CYCLE_LIMIT  = NUM_RANDOM * (cache_pkg::FILL_CYCLES + 2) + 200;
	localparam int EXPECT_HIT   = 0;
	localparam int EXPECT_MISS  = 1;
	localparam int EXPECT_ANY   = 2;

	logic                       clk;
	logic                       rst;
	logic                       pipe_read;
	logic                       pipe_write;
	logic [mem_pkg::ADDR_W-1:0] read_addr;
	logic [mem_pkg::ADDR_W-1:0] write_addr;
	logic [mem_pkg::DATA_W-1:0] write_data;
	logic [mem_pkg::DATA_W-1:0] data_out;
	logic                       stall;
	logic                       cachehit;

	logic [mem_pkg::DATA_W-1:0]  model_mem [mem_pkg::MEM_WORDS];  // memory image
	logic                        model_valid [cache_pkg::SETS];
	logic [cache_pkg::TAG_W-1:0] model_tag [cache_pkg::SETS];
	logic [4:0]  tag_pool [4]   = '{5'd3, 5'd9, 5'd20, 5'd26};     // few tags, so conflicts
	logic [6:0]  index_pool [4] = '{7'd5, 7'd6, 7'd40, 7'd127};
	logic [31:0] rng_state;
	int          mismatch_count;
	int          other_count;
	int          cycle_count = 0;

	mem_system i_dut (
		.clk        (clk),
		.rst        (rst),
		.pipe_read  (pipe_read),
		.pipe_write (pipe_write),
		.read_addr  (read_addr),
		.write_addr (write_addr),
		.write_data (write_data),
		.data_out   (data_out),
		.stall      (stall),
		.cachehit   (cachehit)
	);

	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// tag, set and word in block, byte bit left at zero
	function automatic logic [15:0] make_addr(input logic [4:0] tag, input logic [6:0] index,
			input logic [2:0] word);
		return {tag, index, word, 1'b0};
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// one request from a falling edge until it completes, returns on a falling edge
	task automatic run_op(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
			input int expect_kind);
		logic        pred_hit;
		logic        exp_hit;
		logic [15:0] exp_data;
		int          stall_len;
		pred_hit  = model_valid[addr[10:4]] && (model_tag[addr[10:4]] == addr[15:11]);
		exp_hit   = (expect_kind == EXPECT_ANY) ? pred_hit : (expect_kind == EXPECT_HIT);
		exp_data  = model_mem[addr[15:1]];  // cache copy equals memory under write-through
		stall_len = 0;
		rng_state  = lcg_step(rng_state);
		pipe_read  = ~wr;
		pipe_write = wr;
		read_addr  = wr ? rng_state[31:16] : addr;  // unused port carries noise
		write_addr = wr ? addr : rng_state[31:16];
		write_data = wdata;
		#(SAMPLE_DELAY);
		check_value("stall", 16'd0, 16'(stall));
		check_value("cachehit", 16'(exp_hit), 16'(cachehit));  // directed steps use their intent
		if (!cachehit) begin
			do begin
				@(negedge clk);
				#(SAMPLE_DELAY);
				if (stall) stall_len++;
			end while (stall && stall_len <= cache_pkg::FILL_CYCLES);
		end
		if (stall) begin
			other_count++;
			$display("%0t: stall did not end after %0d cycles", $time, stall_len);
		end else begin
			check_value("stall length", exp_hit ? 16'd0 : 16'(cache_pkg::FILL_CYCLES),
				16'(stall_len));
			check_value("cachehit", 16'd1, 16'(cachehit));
			check_value("data_out", exp_data, data_out);  // old word on a write
		end
		if (!pred_hit) begin
			model_valid[addr[10:4]] = 1'b1;  // fill brought the block in
			model_tag[addr[10:4]]   = addr[15:11];
		end
		if (wr) model_mem[addr[15:1]] = wdata;
		@(negedge clk);
	endtask

	// run limit, counted in clock cycles
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			other_count++;
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		logic        wr;
		logic [15:0] addr;
		clk            = 1'b0;
		rst            = 1'b1;
		pipe_read      = 1'b0;
		pipe_write     = 1'b0;
		read_addr      = '0;
		write_addr     = '0;
		write_data     = '0;
		rng_state      = 32'd22;
		mismatch_count = 0;
		other_count    = 0;
		for (int a = 0; a < mem_pkg::MEM_WORDS; a++) begin
			model_mem[a] = 16'(a) ^ 16'hA5C3;  // initial contents rule
		end
		for (int s = 0; s < cache_pkg::SETS; s++) begin
			model_valid[s] = 1'b0;
			model_tag[s]   = '0;
		end
		repeat (8) @(negedge clk);
		rst = 1'b0;
		#(SAMPLE_DELAY);
		check_value("stall", 16'd0, 16'(stall));  // idle, nothing held
		check_value("cachehit", 16'd0, 16'(cachehit));
		@(negedge clk);
		run_op(1'b0, make_addr(5'd3, 7'd5, 3'd2), 16'h0000, EXPECT_MISS);   // first read fills
		run_op(1'b0, make_addr(5'd3, 7'd5, 3'd0), 16'h0000, EXPECT_HIT);    // same block
		run_op(1'b0, make_addr(5'd3, 7'd5, 3'd7), 16'h0000, EXPECT_HIT);
		run_op(1'b1, make_addr(5'd3, 7'd5, 3'd2), 16'hBEEF, EXPECT_HIT);    // write hit
		run_op(1'b0, make_addr(5'd3, 7'd5, 3'd2), 16'h0000, EXPECT_HIT);
		run_op(1'b0, make_addr(5'd20, 7'd5, 3'd1), 16'h0000, EXPECT_MISS);  // evicts tag 3
		run_op(1'b0, make_addr(5'd3, 7'd5, 3'd2), 16'h0000, EXPECT_MISS);   // value from memory
		run_op(1'b1, make_addr(5'd9, 7'd40, 3'd3), 16'h1234, EXPECT_MISS);  // write miss
		run_op(1'b0, make_addr(5'd9, 7'd40, 3'd3), 16'h0000, EXPECT_HIT);
		for (int n = 0; n < NUM_RANDOM; n++) begin
			rng_state = lcg_step(rng_state);
			wr        = (rng_state[31:30] == 2'b00);  // about one write in four
			addr      = make_addr(tag_pool[rng_state[29:28]], index_pool[rng_state[27:26]],
				rng_state[25:23]);
			addr[0]   = rng_state[22];                // byte bit is ignored
			rng_state = lcg_step(rng_state);
			run_op(wr, addr, rng_state[31:16], EXPECT_ANY);
		end
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count + other_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
design/mem_pkg.sv
design/cache_pkg.sv
design/mem_bus_if.sv
design/tag_array.sv
design/data_array.sv
design/cache_fill_fsm.sv
design/cache.sv
design/main_memory.sv
design/mem_system.sv
bench/mem_system_checker.sv
bench/tb_mem_system.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_system
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
